//--- Makefile
# Verilator build for the AVR-style core and its testbench

VERILATOR  ?= verilator
TOP        ?= tb_avr_core
FILELIST   ?= avr_core.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_TEXT  ?= TEST OK

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- avr_core.f
+incdir+source
source/avr_pkg.sv
source/alu.sv
source/register_file.sv
source/program_rom.sv
source/data_sram.sv
source/io_block.sv
source/control_unit.sv
source/avr_core.sv
testbench/tb_isa_model.sv
testbench/tb_avr_core.sv

//--- source/alu.sv
/*
 * alu
 * 8-bit arithmetic and logic unit producing the Z, N, V and C flags.
 */
`include "avr_core_cfg.svh"

module alu (
    input  avr_pkg::alu_op_e       op,
    input  logic [`AVR_DATA_W-1:0] a,
    input  logic [`AVR_DATA_W-1:0] b,
    input  logic                   carry_in,
    output logic [`AVR_DATA_W-1:0] result,
    output avr_pkg::sreg_t         flags
);

    localparam int W = `AVR_DATA_W;

    logic [W:0] sum;   // carry or borrow in the top bit

    always_comb begin
        sum     = '0;
        flags.c = carry_in;
        flags.v = 1'b0;
        case (op)
            avr_pkg::ALU_ADD, avr_pkg::ALU_ADC: begin
                sum = {1'b0, a} + {1'b0, b}
                      + {{W{1'b0}}, op == avr_pkg::ALU_ADC && carry_in};
                flags.c = sum[W];
                flags.v = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
            end
            avr_pkg::ALU_SUB: begin
                sum     = {1'b0, a} - {1'b0, b};
                flags.c = sum[W];
                flags.v = (a[W-1] != b[W-1]) && (sum[W-1] != a[W-1]);
            end
            avr_pkg::ALU_AND: sum = {1'b0, a & b};
            avr_pkg::ALU_OR:  sum = {1'b0, a | b};
            avr_pkg::ALU_EOR: sum = {1'b0, a ^ b};
            avr_pkg::ALU_INC: begin
                sum     = {1'b0, a + 1'b1};
                flags.v = a == {1'b0, {(W-1){1'b1}}};   // 0x7f wraps
            end
            avr_pkg::ALU_DEC: begin
                sum     = {1'b0, a - 1'b1};
                flags.v = a == {1'b1, {(W-1){1'b0}}};   // 0x80 wraps
            end
            default: sum = {1'b0, b};
        endcase
        result  = sum[W-1:0];
        flags.z = result == '0;
        flags.n = result[W-1];
    end

endmodule

//--- source/avr_core.sv
/*
 * avr_core
 * 8-bit AVR-style microcontroller core: control unit, ALU, register
 * file, program ROM, data SRAM and the port/timer I/O block.
 */
`include "avr_core_cfg.svh"

module avr_core (
    input  logic                   osc_clk,
    input  logic                   corrected_reset,
    input  logic [2:0]             prescaler,
    input  avr_pkg::prog_write_t   prog,
    input  logic [`AVR_DATA_W-1:0] pin_b,
    output logic [`AVR_DATA_W-1:0] port_a_out,
    output logic [`AVR_DATA_W-1:0] port_a_dir,
    output logic                   oc0a,
    output logic                   oc0b
);

    logic [`AVR_PC_W-1:0]   pc;
    avr_pkg::instr_u        instr;
    logic [`AVR_REG_AW-1:0] rr_addr;
    logic [`AVR_REG_AW-1:0] rd_addr;
    logic [`AVR_DATA_W-1:0] rr_data;
    logic [`AVR_DATA_W-1:0] rd_data;
    logic [`AVR_DATA_W-1:0] z_ptr;
    logic                   reg_we;
    logic [`AVR_REG_AW-1:0] reg_waddr;
    logic [`AVR_DATA_W-1:0] reg_wdata;
    avr_pkg::alu_op_e       alu_op;
    logic [`AVR_DATA_W-1:0] alu_a;
    logic [`AVR_DATA_W-1:0] alu_b;
    logic                   alu_cin;
    logic [`AVR_DATA_W-1:0] alu_result;
    avr_pkg::sreg_t         alu_sreg;
    avr_pkg::bus_req_t      dmem_req;
    logic [`AVR_DATA_W-1:0] dmem_rdata;
    avr_pkg::bus_req_t      io_req;
    logic [`AVR_DATA_W-1:0] io_rdata;

    control_unit u_control (
        .osc_clk         (osc_clk),
        .corrected_reset (corrected_reset),
        .prescaler       (prescaler),
        .pc              (pc),
        .instr           (instr),
        .rr_addr         (rr_addr),
        .rd_addr         (rd_addr),
        .rr_data         (rr_data),
        .rd_data         (rd_data),
        .z_ptr           (z_ptr),
        .reg_we          (reg_we),
        .reg_waddr       (reg_waddr),
        .reg_wdata       (reg_wdata),
        .alu_op          (alu_op),
        .alu_a           (alu_a),
        .alu_b           (alu_b),
        .alu_cin         (alu_cin),
        .alu_result      (alu_result),
        .alu_sreg        (alu_sreg),
        .dmem_req        (dmem_req),
        .dmem_rdata      (dmem_rdata),
        .io_req          (io_req),
        .io_rdata        (io_rdata)
    );

    alu u_alu (
        .op       (alu_op),
        .a        (alu_a),
        .b        (alu_b),
        .carry_in (alu_cin),
        .result   (alu_result),
        .flags    (alu_sreg)
    );

    register_file u_regs (
        .osc_clk (osc_clk),
        .rr_addr (rr_addr),
        .rd_addr (rd_addr),
        .rr_data (rr_data),
        .rd_data (rd_data),
        .we      (reg_we),
        .waddr   (reg_waddr),
        .wdata   (reg_wdata),
        .z_ptr   (z_ptr)
    );

    program_rom u_rom (
        .osc_clk         (osc_clk),
        .corrected_reset (corrected_reset),
        .addr            (pc),
        .data            (instr),
        .prog            (prog)
    );

    data_sram u_dmem (
        .osc_clk (osc_clk),
        .req     (dmem_req),
        .rdata   (dmem_rdata)
    );

    io_block u_io (
        .osc_clk         (osc_clk),
        .corrected_reset (corrected_reset),
        .req             (io_req),
        .rdata           (io_rdata),
        .pin_b           (pin_b),
        .port_a_out      (port_a_out),
        .port_a_dir      (port_a_dir),
        .oc0a            (oc0a),
        .oc0b            (oc0b)
    );

endmodule

//--- source/avr_core_cfg.svh
/*
 * avr core configuration
 * Widths, memory depths and I/O register addresses shared by the core.
 */
`ifndef AVR_CORE_CFG_SVH
`define AVR_CORE_CFG_SVH

`define AVR_DATA_W   8
`define AVR_INSTR_W  16
`define AVR_PC_W     10
`define AVR_DMEM_AW  7
`define AVR_IO_AW    6
`define AVR_REG_AW   5

// low I/O space, one word each
`define AVR_IO_DDRA  6'h01
`define AVR_IO_PORTA 6'h02
`define AVR_IO_PINB  6'h03
`define AVR_IO_TCCR0 6'h24
`define AVR_IO_TCNT0 6'h26
`define AVR_IO_OCR0A 6'h27
`define AVR_IO_OCR0B 6'h28

`endif

//--- source/avr_pkg.sv
/*
 * avr_pkg
 * Instruction views, ALU operations, status flags and the
 * programming and bus request structs of the core.
 */
`include "avr_core_cfg.svh"

package avr_pkg;

    // two-register format, also used by inc/dec/ld/st
    typedef struct packed {
        logic [5:0] opcode;
        logic       r_hi;
        logic [4:0] d;
        logic [3:0] r_lo;
    } reg_reg_t;

    typedef struct packed {
        logic [3:0] opcode;
        logic [3:0] k_hi;
        logic [3:0] d;      // r16..r31
        logic [3:0] k_lo;
    } imm_t;

    typedef struct packed {
        logic [4:0] opcode;
        logic [1:0] a_hi;
        logic [4:0] d;
        logic [3:0] a_lo;
    } io_t;

    typedef struct packed {
        logic [1:0] clr;    // 00 branch if set, 01 branch if clear
        logic [6:0] k7;
        logic [2:0] sbit;   // sreg bit tested, 1 is Z
    } cond_br_t;

    typedef union packed {
        logic [11:0] k12;   // rjmp offset
        cond_br_t    cond;
    } br_off_u;

    typedef struct packed {
        logic [3:0] opcode;
        br_off_u    off;
    } branch_t;

    typedef union packed {
        reg_reg_t reg_reg;
        imm_t     imm;
        io_t      io;
        branch_t  branch;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_ADC,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_EOR,
        ALU_INC,
        ALU_DEC,
        ALU_PASS
    } alu_op_e;

    typedef struct packed {
        logic v;
        logic n;
        logic z;
        logic c;
    } sreg_t;

    typedef struct packed {
        logic                    we;
        logic [`AVR_PC_W-1:0]    addr;
        logic [`AVR_INSTR_W-1:0] data;
    } prog_write_t;

    typedef struct packed {
        logic                    cs;
        logic                    we;
        logic [`AVR_DMEM_AW-1:0] addr;
        logic [`AVR_DATA_W-1:0]  wdata;
    } bus_req_t;

endpackage

//--- source/control_unit.sv
/*
 * control_unit
 * Prescaler step strobe, program counter and status register, and a
 * FETCH/EXEC/MEM sequencer that decodes each word and drives the
 * register file, ALU, data SRAM and I/O strobes.
 */
`include "avr_core_cfg.svh"

module control_unit (
    input  logic                   osc_clk,
    input  logic                   corrected_reset,
    input  logic [2:0]             prescaler,
    output logic [`AVR_PC_W-1:0]   pc,
    input  avr_pkg::instr_u        instr,
    output logic [`AVR_REG_AW-1:0] rr_addr,
    output logic [`AVR_REG_AW-1:0] rd_addr,
    input  logic [`AVR_DATA_W-1:0] rr_data,
    input  logic [`AVR_DATA_W-1:0] rd_data,
    input  logic [`AVR_DATA_W-1:0] z_ptr,
    output logic                   reg_we,
    output logic [`AVR_REG_AW-1:0] reg_waddr,
    output logic [`AVR_DATA_W-1:0] reg_wdata,
    output avr_pkg::alu_op_e       alu_op,
    output logic [`AVR_DATA_W-1:0] alu_a,
    output logic [`AVR_DATA_W-1:0] alu_b,
    output logic                   alu_cin,
    input  logic [`AVR_DATA_W-1:0] alu_result,
    input  avr_pkg::sreg_t         alu_sreg,
    output avr_pkg::bus_req_t      dmem_req,
    input  logic [`AVR_DATA_W-1:0] dmem_rdata,
    output avr_pkg::bus_req_t      io_req,
    input  logic [`AVR_DATA_W-1:0] io_rdata
);

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM
    } state_e;

    state_e               state;
    avr_pkg::sreg_t       sreg;
    logic [6:0]           ps_cnt;
    logic [6:0]           ps_mask;
    logic                 step;
    logic                 exec_step;
    logic                 is_ldi;
    logic                 is_mov;
    logic                 is_arith;
    logic                 is_ld;
    logic                 is_st;
    logic                 is_in;
    logic                 is_out;
    logic                 is_rjmp;
    logic                 is_brz;
    logic                 br_taken;
    logic [`AVR_PC_W-1:0] pc_inc;
    logic [`AVR_PC_W-1:0] pc_next;

    // step every 2^p cycles, every cycle for p = 0
    assign ps_mask   = 7'((7'd1 << prescaler) - 7'd1);
    assign step      = (ps_cnt & ps_mask) == ps_mask;
    assign exec_step = step && state == EXEC;

    assign is_ldi  = instr.imm.opcode == 4'b1110;
    assign is_mov  = instr.reg_reg.opcode == 6'b001011;
    assign is_ld   = instr.reg_reg.opcode == 6'b100000 && !instr.reg_reg.r_hi
                     && instr.reg_reg.r_lo == 4'b0000;
    assign is_st   = instr.reg_reg.opcode == 6'b100000 && instr.reg_reg.r_hi
                     && instr.reg_reg.r_lo == 4'b0000;
    assign is_in   = instr.io.opcode == 5'b10110;
    assign is_out  = instr.io.opcode == 5'b10111;
    assign is_rjmp = instr.branch.opcode == 4'b1100;
    assign is_brz  = instr.branch.opcode == 4'b1111 && !instr.branch.off.cond.clr[1]
                     && instr.branch.off.cond.sbit == 3'd1;

    // breq when clr[0] is 0, brne when 1
    assign br_taken = is_brz && (instr.branch.off.cond.clr[0] ? !sreg.z : sreg.z);

    always_comb begin
        alu_op = avr_pkg::ALU_PASS;
        case (instr.reg_reg.opcode)
            6'b000011: alu_op = avr_pkg::ALU_ADD;
            6'b000111: alu_op = avr_pkg::ALU_ADC;
            6'b000110: alu_op = avr_pkg::ALU_SUB;
            6'b001000: alu_op = avr_pkg::ALU_AND;
            6'b001001: alu_op = avr_pkg::ALU_EOR;
            6'b001010: alu_op = avr_pkg::ALU_OR;
            6'b100101: begin
                if (!instr.reg_reg.r_hi && instr.reg_reg.r_lo == 4'b0011)
                    alu_op = avr_pkg::ALU_INC;
                else if (!instr.reg_reg.r_hi && instr.reg_reg.r_lo == 4'b1010)
                    alu_op = avr_pkg::ALU_DEC;
            end
            default: ;
        endcase
    end

    assign is_arith = alu_op != avr_pkg::ALU_PASS;

    // ldi and mov go through the alu as pass
    assign rd_addr = instr.reg_reg.d;
    assign rr_addr = {instr.reg_reg.r_hi, instr.reg_reg.r_lo};
    assign alu_a   = rd_data;
    assign alu_b   = is_ldi ? {instr.imm.k_hi, instr.imm.k_lo} : rr_data;
    assign alu_cin = sreg.c;

    assign reg_we    = step && ((state == EXEC && (is_ldi || is_mov || is_arith))
                                || state == MEM);
    assign reg_waddr = is_ldi ? {1'b1, instr.imm.d} : instr.reg_reg.d;
    assign reg_wdata = (state == MEM) ? (is_in ? io_rdata : dmem_rdata) : alu_result;

    always_comb begin
        dmem_req       = '0;
        dmem_req.cs    = exec_step && (is_ld || is_st);
        dmem_req.we    = exec_step && is_st;
        dmem_req.addr  = z_ptr[`AVR_DMEM_AW-1:0];
        dmem_req.wdata = rd_data;
        io_req         = '0;
        io_req.cs      = exec_step && (is_in || is_out);
        io_req.we      = exec_step && is_out;
        io_req.addr    = {{(`AVR_DMEM_AW - `AVR_IO_AW){1'b0}}, instr.io.a_hi, instr.io.a_lo};
        io_req.wdata   = rd_data;
    end

    assign pc_inc = pc + 1'b1;

    always_comb begin
        pc_next = pc_inc;
        if (is_rjmp)
            pc_next = pc_inc + instr.branch.off.k12[`AVR_PC_W-1:0];
        else if (br_taken)
            pc_next = pc_inc + {{(`AVR_PC_W - 7){instr.branch.off.cond.k7[6]}},
                                instr.branch.off.cond.k7};
    end

    always_ff @(posedge osc_clk or posedge corrected_reset) begin
        if (corrected_reset) begin
            ps_cnt <= '0;
            state  <= FETCH;
            pc     <= '0;
            sreg   <= '0;
        end else begin
            ps_cnt <= ps_cnt + 7'd1;
            if (step) begin
                case (state)
                    FETCH: state <= EXEC;   // rom output settles on pc
                    EXEC: begin
                        if (is_arith)
                            sreg <= alu_sreg;
                        if (is_ld || is_in) begin
                            state <= MEM;   // hold pc so instr stays valid
                        end else begin
                            state <= FETCH;
                            pc    <= pc_next;
                        end
                    end
                    MEM: begin
                        state <= FETCH;
                        pc    <= pc_inc;
                    end
                    default: state <= FETCH;
                endcase
            end
        end
    end

    // data memory and I/O never share a cycle
    bus_exclusive: assert property (@(posedge osc_clk) disable iff (corrected_reset)
        !(dmem_req.cs && io_req.cs));

endmodule

//--- source/data_sram.sv
/*
 * data_sram
 * 128 x 8 synchronous data memory, read data held until the next read.
 */
`include "avr_core_cfg.svh"

module data_sram (
    input  logic                   osc_clk,
    input  avr_pkg::bus_req_t      req,
    output logic [`AVR_DATA_W-1:0] rdata
);

    logic [`AVR_DATA_W-1:0] mem [0:(1 << `AVR_DMEM_AW)-1];

    always_ff @(posedge osc_clk) begin
        if (req.cs && req.we)
            mem[req.addr] <= req.wdata;
        if (req.cs && !req.we)
            rdata <= mem[req.addr];
    end

endmodule

//--- source/io_block.sv
/*
 * io_block
 * I/O register space: port A output and direction, synchronized
 * port B inputs, and timer 0 with two compare outputs.
 */
`include "avr_core_cfg.svh"

module io_block (
    input  logic                   osc_clk,
    input  logic                   corrected_reset,
    input  avr_pkg::bus_req_t      req,
    output logic [`AVR_DATA_W-1:0] rdata,
    input  logic [`AVR_DATA_W-1:0] pin_b,
    output logic [`AVR_DATA_W-1:0] port_a_out,
    output logic [`AVR_DATA_W-1:0] port_a_dir,
    output logic                   oc0a,
    output logic                   oc0b
);

    localparam logic [`AVR_DMEM_AW-1:0] A_PORTA = `AVR_IO_PORTA;
    localparam logic [`AVR_DMEM_AW-1:0] A_DDRA  = `AVR_IO_DDRA;
    localparam logic [`AVR_DMEM_AW-1:0] A_PINB  = `AVR_IO_PINB;
    localparam logic [`AVR_DMEM_AW-1:0] A_TCNT0 = `AVR_IO_TCNT0;
    localparam logic [`AVR_DMEM_AW-1:0] A_OCR0A = `AVR_IO_OCR0A;
    localparam logic [`AVR_DMEM_AW-1:0] A_OCR0B = `AVR_IO_OCR0B;
    localparam logic [`AVR_DMEM_AW-1:0] A_TCCR0 = `AVR_IO_TCCR0;

    logic                   wr;
    logic [`AVR_DATA_W-1:0] pinb_meta;
    logic [`AVR_DATA_W-1:0] pinb_sync;
    logic [`AVR_DATA_W-1:0] tcnt0;
    logic [`AVR_DATA_W-1:0] ocr0a;
    logic [`AVR_DATA_W-1:0] ocr0b;
    logic [`AVR_DATA_W-1:0] tccr0;

    assign wr = req.cs && req.we;

    always_ff @(posedge osc_clk or posedge corrected_reset) begin
        if (corrected_reset) begin
            port_a_out <= '0;
            port_a_dir <= '0;
            ocr0a      <= '0;
            ocr0b      <= '0;
            tccr0      <= '0;
        end else if (wr) begin
            case (req.addr)
                A_PORTA: port_a_out <= req.wdata;
                A_DDRA:  port_a_dir <= req.wdata;
                A_OCR0A: ocr0a      <= req.wdata;
                A_OCR0B: ocr0b      <= req.wdata;
                A_TCCR0: tccr0      <= req.wdata;
                default: ;
            endcase
        end
    end

    always_ff @(posedge osc_clk or posedge corrected_reset) begin
        if (corrected_reset) begin
            pinb_meta <= '0;
            pinb_sync <= '0;
            tcnt0     <= '0;
        end else begin
            pinb_meta <= pin_b;
            pinb_sync <= pinb_meta;
            if (wr && req.addr == A_TCNT0)
                tcnt0 <= req.wdata;
            else if (tccr0[0])   // bit 0 enables the count
                tcnt0 <= tcnt0 + 1'b1;
        end
    end

    always_ff @(posedge osc_clk) begin
        if (req.cs && !req.we) begin
            case (req.addr)
                A_PORTA: rdata <= port_a_out;
                A_DDRA:  rdata <= port_a_dir;
                A_PINB:  rdata <= pinb_sync;
                A_TCNT0: rdata <= tcnt0;
                A_OCR0A: rdata <= ocr0a;
                A_OCR0B: rdata <= ocr0b;
                A_TCCR0: rdata <= tccr0;
                default: rdata <= '0;
            endcase
        end
    end

    assign oc0a = tcnt0 < ocr0a;
    assign oc0b = tcnt0 < ocr0b;

endmodule

//--- source/program_rom.sv
/*
 * program_rom
 * 1024 x 16 instruction memory with a registered read and a
 * programming write port that is only honoured during reset.
 */
`include "avr_core_cfg.svh"

module program_rom (
    input  logic                 osc_clk,
    input  logic                 corrected_reset,
    input  logic [`AVR_PC_W-1:0] addr,
    output avr_pkg::instr_u      data,
    input  avr_pkg::prog_write_t prog
);

    logic [`AVR_INSTR_W-1:0] mem [0:(1 << `AVR_PC_W)-1];

    always_ff @(posedge osc_clk) begin
        if (prog.we && corrected_reset)
            mem[prog.addr] <= prog.data;
        data <= mem[addr];
    end

    // loader must keep the core in reset while it writes
    prog_in_reset: assert property (@(posedge osc_clk) prog.we |-> corrected_reset)
        else $error("program write while core is running");

endmodule

//--- source/register_file.sv
/*
 * register_file
 * 32 x 8 general registers, two combinational reads, one write port.
 */
`include "avr_core_cfg.svh"

module register_file (
    input  logic                   osc_clk,
    input  logic [`AVR_REG_AW-1:0] rr_addr,
    input  logic [`AVR_REG_AW-1:0] rd_addr,
    output logic [`AVR_DATA_W-1:0] rr_data,
    output logic [`AVR_DATA_W-1:0] rd_data,
    input  logic                   we,
    input  logic [`AVR_REG_AW-1:0] waddr,
    input  logic [`AVR_DATA_W-1:0] wdata,
    output logic [`AVR_DATA_W-1:0] z_ptr
);

    logic [`AVR_DATA_W-1:0] regs [0:(1 << `AVR_REG_AW)-1];

    assign rr_data = regs[rr_addr];
    assign rd_data = regs[rd_addr];
    assign z_ptr   = regs[30];   // low byte of Z

    always_ff @(posedge osc_clk) begin
        if (we)
            regs[waddr] <= wdata;
    end

endmodule

//--- testbench/tb_avr_core.sv
/*
 * tb_avr_core
 * Loads random programs through the programming port, runs them at
 * several prescaler settings and compares port A against the model.
 */
`include "avr_core_cfg.svh"

module tb_avr_core;

    logic                 osc_clk;
    logic                 corrected_reset;
    logic [2:0]           prescaler;
    avr_pkg::prog_write_t prog;
    logic [7:0]           pin_b;
    logic [7:0]           port_a_out;
    logic [7:0]           port_a_dir;
    logic                 oc0a;
    logic                 oc0b;
    int                   tests;
    int                   failed;

    avr_core u_dut (
        .osc_clk         (osc_clk),
        .corrected_reset (corrected_reset),
        .prescaler       (prescaler),
        .prog            (prog),
        .pin_b           (pin_b),
        .port_a_out      (port_a_out),
        .port_a_dir      (port_a_dir),
        .oc0a            (oc0a),
        .oc0b            (oc0b)
    );

    initial begin
        osc_clk = 1'b0;
        forever #20 osc_clk = ~osc_clk;
    end

    task automatic load_and_reset(input logic [2:0] p);
        @(posedge osc_clk);
        corrected_reset <= 1'b1;
        prescaler       <= p;
        pin_b           <= tb_isa_model::pinb;
        for (int i = 0; i < tb_isa_model::words.size(); i++) begin
            @(posedge osc_clk);
            prog <= {1'b1, 10'(i), tb_isa_model::words[i]};
        end
        @(posedge osc_clk);
        prog <= '0;
        repeat (8) @(posedge osc_clk);
        corrected_reset <= 1'b0;
    endtask

    // sampled on the falling edge, away from the DUT's updates
    task automatic wait_for_value(input logic on_out, input logic [7:0] value,
                                  input int limit, output logic ok);
        int n;
        n  = 0;
        ok = 1'b1;
        @(negedge osc_clk);
        while ((on_out ? port_a_out : port_a_dir) !== value) begin
            if (n == limit) begin
                ok = 1'b0;
                return;
            end
            n++;
            @(negedge osc_clk);
        end
    endtask

    task automatic note_result(input string name, input logic good);
        tests++;
        if (!good)
            failed++;
        $display("test %0d %s: %s", tests, name, good ? "pass" : "fail");
    endtask

    task automatic check_program(input int kind, input logic [2:0] p);
        logic ok;
        logic good;
        good = 1'b1;
        load_and_reset(p);
        for (int i = 0; i < tb_isa_model::expected.size(); i++) begin
            wait_for_value(1'b0, 8'(i + 1), 600 << p, ok);
            if (!ok) begin
                $display("timeout: result %0d of program kind %0d never appeared", i + 1, kind);
                good = 1'b0;
                break;
            end
            assert (port_a_out == tb_isa_model::expected[i])
            else begin
                $display("Fail %0t: kind %0d prescaler %0d result %0d got %h expected %h",
                         $time, kind, p, i + 1, port_a_out, tb_isa_model::expected[i]);
                good = 1'b0;
            end
        end
        note_result($sformatf("program kind %0d prescaler %0d", kind, p), good);
    endtask

    task automatic check_timer();
        logic [7:0] ocra;
        logic [7:0] ocrb;
        logic [7:0] cnt;
        logic       ok;
        logic       good;
        good = 1'b1;
        ocra = 8'(tb_isa_model::next_random());
        ocrb = 8'(tb_isa_model::next_random());
        tb_isa_model::words = {};
        tb_isa_model::words.push_back(tb_isa_model::ldi_word(5'd16, ocra));
        tb_isa_model::words.push_back(tb_isa_model::io_word(1'b1, `AVR_IO_OCR0A, 5'd16));
        tb_isa_model::words.push_back(tb_isa_model::ldi_word(5'd17, ocrb));
        tb_isa_model::words.push_back(tb_isa_model::io_word(1'b1, `AVR_IO_OCR0B, 5'd17));
        tb_isa_model::words.push_back(tb_isa_model::ldi_word(5'd18, 8'd1));
        tb_isa_model::words.push_back(tb_isa_model::io_word(1'b1, `AVR_IO_TCCR0, 5'd18));
        tb_isa_model::words.push_back(tb_isa_model::io_word(1'b1, `AVR_IO_PORTA, 5'd18));
        tb_isa_model::words.push_back(16'hCFFF);
        load_and_reset(3'd0);
        wait_for_value(1'b1, 8'd1, 600, ok);
        if (!ok) begin
            $display("timeout: timer program never wrote port A");
            good = 1'b0;
        end else begin
            cnt = 8'd2;   // enabled two cycles before the port A write lands
            repeat (256) begin
                assert (oc0a == (cnt < ocra) && oc0b == (cnt < ocrb))
                else begin
                    $display("Fail %0t: count %h ocr0a %h ocr0b %h gave oc0a %b oc0b %b",
                             $time, cnt, ocra, ocrb, oc0a, oc0b);
                    good = 1'b0;
                end
                @(negedge osc_clk);
                cnt++;
            end
        end
        note_result("timer compare", good);
    endtask

    initial begin
        corrected_reset <= 1'b1;
        prescaler       <= 3'd0;
        prog            <= '0;
        pin_b           <= 8'h00;
        tests  = 0;
        failed = 0;
        for (int t = 0; t < 12; t++) begin
            tb_isa_model::build_program(t % 3);
            tb_isa_model::execute_program();
            check_program(t % 3, 3'd0);
            check_program(t % 3, 3'(1 + {tb_isa_model::next_random()} % 7));
        end
        repeat (2) check_timer();
        $display("%0d tests, %0d passed, %0d failed", tests, tests - failed, failed);
        if (failed == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- testbench/tb_isa_model.sv
/*
 * tb_isa_model
 * Random program generator and architectural reference model for the
 * instruction subset. Each program reports results through port A.
 */
`include "avr_core_cfg.svh"

package tb_isa_model;

    integer      seed = 71;
    logic [15:0] words[$];
    logic [7:0]  expected[$];   // port A value at each DDRA marker write
    logic [7:0]  pinb;

    function automatic int next_random();
        return $random(seed);
    endfunction

    function automatic logic [15:0] rr_word(logic [5:0] op, logic [4:0] d, logic [4:0] r);
        return {op, r[4], d, r[3:0]};
    endfunction

    function automatic logic [15:0] ldi_word(logic [4:0] d, logic [7:0] k);
        return {4'hE, k[7:4], d[3:0], k[3:0]};
    endfunction

    function automatic logic [15:0] io_word(logic out, logic [5:0] a, logic [4:0] d);
        return {4'b1011, out, a[5:4], d, a[3:0]};
    endfunction

    function automatic logic [4:0] pick_reg();
        return 5'(16 + {next_random()} % 14);   // r30 and r31 stay reserved
    endfunction

    function automatic logic [15:0] alu_word();
        int         sel;
        logic [4:0] d;
        logic [4:0] r;
        sel = {next_random()} % 9;
        d   = pick_reg();
        r   = pick_reg();
        case (sel)
            0: return rr_word(6'b001011, d, r);   // mov
            1: return rr_word(6'b000011, d, r);
            2: return rr_word(6'b000111, d, r);
            3: return rr_word(6'b000110, d, r);
            4: return rr_word(6'b001000, d, r);
            5: return rr_word(6'b001001, d, r);
            6: return rr_word(6'b001010, d, r);
            7: return {7'b1001010, d, 4'h3};       // inc
            default: return {7'b1001010, d, 4'hA}; // dec
        endcase
    endfunction

    // out PORTA then a numbered DDRA write that marks the value as final
    function automatic void append_output(logic [4:0] r, logic [7:0] mark);
        words.push_back(io_word(1'b1, `AVR_IO_PORTA, r));
        words.push_back(ldi_word(5'd31, mark));
        words.push_back(io_word(1'b1, `AVR_IO_DDRA, 5'd31));
    endfunction

    function automatic void build_program(int kind);
        logic [7:0] addr[$];
        logic [4:0] r;
        words = {};
        pinb  = 8'(next_random());
        for (int i = 16; i < 30; i++)
            words.push_back(ldi_word(5'(i), 8'(next_random())));
        case (kind)
            0: begin
                repeat (4 + {next_random()} % 8)
                    words.push_back(alu_word());
                append_output(pick_reg(), 8'd1);
                words.push_back({5'b11110, 1'(next_random()), 7'd2, 3'd1}); // breq or brne
                words.push_back(ldi_word(5'd17, 8'h5a));
                words.push_back({4'hC, 12'd1});
                words.push_back(ldi_word(5'd17, 8'ha5));
                append_output(5'd17, 8'd2);
            end
            1: begin
                repeat (3) begin
                    addr.push_back(8'(next_random()));
                    words.push_back(ldi_word(5'd30, addr[$]));
                    words.push_back(rr_word(6'b100000, pick_reg(), 5'h10)); // st
                end
                for (int i = 2; i >= 0; i--) begin
                    r = pick_reg();
                    words.push_back(ldi_word(5'd30, addr[i]));
                    words.push_back(rr_word(6'b100000, r, 5'h00));          // ld
                    append_output(r, 8'(3 - i));
                end
            end
            default: begin
                r = pick_reg();
                words.push_back(io_word(1'b0, `AVR_IO_PINB, r));
                append_output(r, 8'd1);
            end
        endcase
        words.push_back(16'hCFFF);   // rjmp to itself
    endfunction

    function automatic void execute_program();
        logic [7:0]  rf [32];
        logic [7:0]  mem [128];
        logic [15:0] w;
        logic [7:0]  a;
        logic [7:0]  b;
        logic [8:0]  s;
        logic [7:0]  porta;
        logic [4:0]  d;
        logic [5:0]  io_a;
        logic        z;
        logic        c;
        logic        upd;
        int          pc;
        expected = {};
        {z, c} = '0;
        porta = '0;
        pc = 0;
        for (int steps = 0; steps < 4000; steps++) begin
            w    = words[pc];
            d    = w[8:4];
            a    = rf[d];
            b    = rf[{w[9], w[3:0]}];
            io_a = {w[10:9], w[3:0]};
            upd  = 1'b0;
            pc   = pc + 1;
            if (w == 16'hCFFF)
                break;
            if (w[15:12] == 4'hE)
                rf[{1'b1, w[7:4]}] = {w[11:8], w[3:0]};
            else if (w[15:10] == 6'b001011)
                rf[d] = b;
            else if (w[15:12] == 4'hC)
                pc = pc + $signed(w[11:0]);
            else if (w[15:11] == 5'b11110 && w[2:0] == 3'd1) begin
                if (z ^ w[10])
                    pc = pc + $signed(w[9:3]);
            end else if ((w & 16'hFE0F) == 16'h8000)
                rf[d] = mem[rf[30][6:0]];
            else if ((w & 16'hFE0F) == 16'h8200)
                mem[rf[30][6:0]] = a;
            else if (w[15:11] == 5'b10110)
                rf[d] = (io_a == `AVR_IO_PINB) ? pinb : 8'h00;
            else if (w[15:11] == 5'b10111) begin
                if (io_a == `AVR_IO_PORTA)
                    porta = a;
                if (io_a == `AVR_IO_DDRA)
                    expected.push_back(porta);
            end else begin
                upd = 1'b1;
                case (w[15:10])
                    6'b000011, 6'b000111: begin
                        s = {1'b0, a} + b + ((w[15:10] == 6'b000111) ? c : 1'b0);
                        c = s[8];
                        rf[d] = s[7:0];
                    end
                    6'b000110: begin
                        s = {1'b0, a} - b;
                        c = a < b;   // borrow
                        rf[d] = s[7:0];
                    end
                    6'b001000: rf[d] = a & b;
                    6'b001001: rf[d] = a ^ b;
                    6'b001010: rf[d] = a | b;
                    default: begin
                        if ((w & 16'hFE0F) == 16'h9403)
                            rf[d] = a + 8'd1;
                        else if ((w & 16'hFE0F) == 16'h940A)
                            rf[d] = a - 8'd1;
                        else
                            upd = 1'b0;   // anything else is a nop
                    end
                endcase
            end
            if (upd)
                z = rf[d] == 8'h00;
        end
    endfunction

endpackage
